// File: mem_wb_unit.f
common/rv32i_pkg.sv
verilog/dmem_port.sv
verilog/mem_wb_reg.sv
verilog/wb_select.sv
verilog/reg_file.sv
verilog/mem_wb_unit.sv
bench/dmem_model.sv
bench/mem_wb_unit_tb.sv

// File: Bender.yml
package:
  name: mem_wb_unit

sources:
  - common/rv32i_pkg.sv
  - verilog/dmem_port.sv
  - verilog/mem_wb_reg.sv
  - verilog/wb_select.sv
  - verilog/reg_file.sv
  - verilog/mem_wb_unit.sv
  - target: test
    files:
      - bench/dmem_model.sv
      - bench/mem_wb_unit_tb.sv

// File: bench/mem_wb_unit_tb.sv
`default_nettype none

module mem_wb_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv32i_pkg::*;

    localparam int NUM_INSTR  = 300;
    localparam int WAIT_LIMIT = 100;

    typedef struct packed {
        reg_idx_t rd;
        logic     we;
        word_t    data;
        logic     halt;
    } wb_exp_t;

    logic       clk;
    logic       rst;
    logic       instr_valid_i;
    logic       mem_read_i;
    logic       mem_write_i;
    funct3_t    funct3_i;
    wb_sel_t    wb_sel_i;
    logic       reg_write_i;
    reg_idx_t   rd_i;
    word_t      alu_out_i;
    word_t      store_data_i;
    word_t      pc_plus4_i;
    word_t      u_imm_i;
    logic       halt_i;
    reg_idx_t   rs_addr_i;
    word_t      rs_data_o;
    logic       dmem_req_o;
    logic       dmem_we_o;
    word_t      dmem_addr_o;
    byte_mask_t dmem_mask_o;
    word_t      dmem_wdata_o;
    logic       dmem_ack_i;
    word_t      dmem_rdata_i;
    logic       stall_o;
    logic       wb_valid_o;
    logic       wb_we_o;
    reg_idx_t   wb_rd_o;
    word_t      wb_data_o;
    logic       halt_o;

    int         errors = 0;
    wb_exp_t    exp_q[$];        // writebacks in program order
    word_t      ref_mem [256];
    word_t      arch_regs [32];  // committed register state
    logic       halt_seen;
    bit         run_ok;

    // expected memory request of the instruction in the memory stage
    logic       exp_we;
    word_t      exp_addr;
    byte_mask_t exp_mask;
    word_t      exp_wdata;

    logic       prev_req, prev_ack, prev_we;
    word_t      prev_addr, prev_wdata;
    byte_mask_t prev_mask;

    mem_wb_unit dut0 (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .mem_read_i    (mem_read_i),
        .mem_write_i   (mem_write_i),
        .funct3_i      (funct3_i),
        .wb_sel_i      (wb_sel_i),
        .reg_write_i   (reg_write_i),
        .rd_i          (rd_i),
        .alu_out_i     (alu_out_i),
        .store_data_i  (store_data_i),
        .pc_plus4_i    (pc_plus4_i),
        .u_imm_i       (u_imm_i),
        .halt_i        (halt_i),
        .dmem_req_o    (dmem_req_o),
        .dmem_we_o     (dmem_we_o),
        .dmem_addr_o   (dmem_addr_o),
        .dmem_mask_o   (dmem_mask_o),
        .dmem_wdata_o  (dmem_wdata_o),
        .dmem_ack_i    (dmem_ack_i),
        .dmem_rdata_i  (dmem_rdata_i),
        .rs_addr_i     (rs_addr_i),
        .rs_data_o     (rs_data_o),
        .stall_o       (stall_o),
        .wb_valid_o    (wb_valid_o),
        .wb_we_o       (wb_we_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .halt_o        (halt_o)
    );

    dmem_model dmem0 (
        .clk     (clk),
        .rst     (rst),
        .req_i   (dmem_req_o),
        .we_i    (dmem_we_o),
        .addr_i  (dmem_addr_o),
        .mask_i  (dmem_mask_o),
        .wdata_i (dmem_wdata_o),
        .ack_o   (dmem_ack_i),
        .rdata_o (dmem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // same initial contents as the memory model
    function automatic word_t fill_word(input int i);
        return {8'(i), 8'(~i), 8'(i ^ 8'h5a), 8'(i + 8'h33)};
    endfunction

    // pick the addressed lane and extend as funct3 says
    function automatic word_t load_extend(input word_t w, input int off, input funct3_t f3);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = (off >= 2) ? w[31:16] : w[15:0];
        case (f3)
            F3_B:    return {{24{b[7]}}, b};
            F3_BU:   return {24'h0, b};
            F3_H:    return {{16{h[15]}}, h};
            F3_HU:   return {16'h0, h};
            default: return w;
        endcase
    endfunction

    function automatic byte_mask_t store_mask(input funct3_t f3, input int off);
        byte_mask_t m;
        m = '0;
        for (int k = 0; k < 4; k++) begin
            if (f3 == F3_W) m[k] = 1'b1;
            else if (f3 == F3_H) m[k] = (k == off) || (k == off + 1);
            else m[k] = (k == off);
        end
        return m;
    endfunction

    // lowest bytes of the store value moved up to the enabled lanes
    function automatic word_t store_lanes(input byte_mask_t m, input int off, input word_t sd);
        word_t w;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            if (m[k]) w[8*k +: 8] = sd[8*(k - off) +: 8];
        end
        return w;
    endfunction

    task automatic wait_accept(output bit ok);
        int n;
        n = 0;
        @(negedge clk);
        while (stall_o && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (stall_o) begin
            errors++;
            $display("timeout: instruction never left the memory stage");
            ok = 1'b0;
        end else begin
            @(posedge clk); // accepted at this edge
            ok = 1'b1;
        end
    endtask

    task automatic send_random_instr(input logic is_halt, output bit ok);
        int         kind;
        int         pick;
        int         off;
        int         widx;
        logic       rw, mr, mw;
        funct3_t    f3;
        wb_sel_t    sel;
        reg_idx_t   rd;
        word_t      alu, sd, pc4, uimm, exp_data;
        word_t      lanes;
        byte_mask_t m;
        wb_exp_t    e;
        kind = is_halt ? 0 : int'($urandom_range(5, 0));
        rd   = reg_idx_t'($urandom_range(31, 0));
        alu  = $urandom();
        sd   = $urandom();
        pc4  = $urandom() & 32'hffff_fffc;
        uimm = $urandom() & 32'hffff_f000;
        rw = 1'b1;
        mr = 1'b0;
        mw = 1'b0;
        f3 = F3_W;
        sel = WB_ALU;
        exp_data = alu;
        off = 0;
        m = 4'hf;
        lanes = '0;
        case (kind)
            1: begin
                sel = WB_PC4;
                exp_data = pc4;
            end
            2: begin
                sel = WB_IMM;
                exp_data = uimm;
            end
            3, 4: begin // load
                pick = $urandom_range(4, 0);
                f3 = (pick == 0) ? F3_B : (pick == 1) ? F3_BU :
                     (pick == 2) ? F3_H : (pick == 3) ? F3_HU : F3_W;
                if (f3 == F3_B || f3 == F3_BU) off = $urandom_range(3, 0);
                else if (f3 == F3_H || f3 == F3_HU) off = 2 * $urandom_range(1, 0);
                widx = $urandom_range(31, 0);
                alu = word_t'(widx * 4 + off);
                mr = 1'b1;
                sel = WB_MEM;
                exp_data = load_extend(ref_mem[widx], off, f3);
            end
            5: begin // store
                pick = $urandom_range(2, 0);
                f3 = (pick == 0) ? F3_B : (pick == 1) ? F3_H : F3_W;
                if (f3 == F3_B) off = $urandom_range(3, 0);
                else if (f3 == F3_H) off = 2 * $urandom_range(1, 0);
                widx = $urandom_range(31, 0);
                alu = word_t'(widx * 4 + off);
                mw = 1'b1;
                rw = 1'b0;
                m = store_mask(f3, off);
                lanes = store_lanes(m, off, sd);
                for (int k = 0; k < 4; k++) begin
                    if (m[k]) ref_mem[widx][8*k +: 8] = lanes[8*k +: 8];
                end
            end
            default: ;
        endcase
        exp_we    = mw;
        exp_addr  = {alu[31:2], 2'b00};
        exp_mask  = m;
        exp_wdata = lanes;
        e.rd   = rd;
        e.we   = rw && rd != '0;
        e.data = exp_data;
        e.halt = is_halt;
        exp_q.push_back(e);
        instr_valid_i <= 1'b1;
        mem_read_i    <= mr;
        mem_write_i   <= mw;
        funct3_i      <= f3;
        wb_sel_i      <= sel;
        reg_write_i   <= rw;
        rd_i          <= rd;
        alu_out_i     <= alu;
        store_data_i  <= sd;
        pc_plus4_i    <= pc4;
        u_imm_i       <= uimm;
        halt_i        <= is_halt;
        wait_accept(ok);
    endtask

    task automatic wait_for_halt(output bit ok);
        int n;
        n = 0;
        while (!halt_seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = halt_seen;
        if (!halt_seen) begin
            errors++;
            $display("timeout: halt never reached writeback");
        end
    endtask

    // random register reads every cycle
    always @(posedge clk) begin
        rs_addr_i <= reg_idx_t'($urandom_range(31, 0));
    end

    always @(negedge clk) begin : check_outputs
        wb_exp_t e;
        if (rst) begin
            prev_req = 1'b0;
            prev_ack = 1'b0;
        end else begin
            if (rs_addr_i == '0) begin
                assert (rs_data_o == '0) else begin
                    errors++;
                    $display("ERROR rs_data_o: got %h expected %h", rs_data_o, 32'h0);
                end
            end
            assert (rs_data_o == arch_regs[rs_addr_i]) else begin
                errors++;
                $display("ERROR rs_data_o: got %h expected %h", rs_data_o,
                         arch_regs[rs_addr_i]);
            end

            if (wb_valid_o) begin
                if (halt_seen) begin
                    errors++;
                    $display("writeback seen after the halt instruction");
                end else if (exp_q.size() == 0) begin
                    errors++;
                    $display("writeback seen with no instruction outstanding");
                end else begin
                    e = exp_q.pop_front();
                    assert (wb_rd_o == e.rd) else begin
                        errors++;
                        $display("ERROR wb_rd_o: got %h expected %h", wb_rd_o, e.rd);
                    end
                    assert (wb_we_o == e.we) else begin
                        errors++;
                        $display("ERROR wb_we_o: got %h expected %h", wb_we_o, e.we);
                    end
                    if (e.we) begin
                        assert (wb_data_o == e.data) else begin
                            errors++;
                            $display("ERROR wb_data_o: got %h expected %h", wb_data_o, e.data);
                        end
                        arch_regs[e.rd] = e.data;
                    end
                    assert (halt_o == e.halt) else begin
                        errors++;
                        $display("ERROR halt_o: got %h expected %h", halt_o, e.halt);
                    end
                    if (e.halt) halt_seen = 1'b1;
                end
            end else begin
                assert (!halt_o) else begin
                    errors++;
                    $display("halt_o is high without a valid writeback");
                end
            end

            // four-phase handshake rules
            if (prev_req && !dmem_req_o) begin
                assert (prev_ack) else begin
                    errors++;
                    $display("dmem_req_o dropped before dmem_ack_i was high");
                end
            end
            if (!prev_req && dmem_req_o) begin
                assert (!prev_ack && !dmem_ack_i) else begin
                    errors++;
                    $display("dmem_req_o rose while dmem_ack_i was still high");
                end
            end
            if (prev_req && dmem_req_o) begin
                assert (dmem_addr_o == prev_addr && dmem_we_o == prev_we &&
                        dmem_mask_o == prev_mask && dmem_wdata_o == prev_wdata) else begin
                    errors++;
                    $display("memory request changed while dmem_req_o was high");
                end
            end
            if (dmem_req_o || dmem_ack_i) begin
                assert (stall_o) else begin
                    errors++;
                    $display("stall_o dropped before the handshake completed");
                end
            end
            if (dmem_req_o) begin
                assert (dmem_addr_o == exp_addr) else begin
                    errors++;
                    $display("ERROR dmem_addr_o: got %h expected %h", dmem_addr_o, exp_addr);
                end
                assert (dmem_we_o == exp_we) else begin
                    errors++;
                    $display("ERROR dmem_we_o: got %h expected %h", dmem_we_o, exp_we);
                end
                if (dmem_we_o) begin
                    assert (dmem_mask_o == exp_mask) else begin
                        errors++;
                        $display("ERROR dmem_mask_o: got %h expected %h", dmem_mask_o, exp_mask);
                    end
                    assert (dmem_wdata_o == exp_wdata) else begin
                        errors++;
                        $display("ERROR dmem_wdata_o: got %h expected %h", dmem_wdata_o,
                                 exp_wdata);
                    end
                end
            end
            prev_req   = dmem_req_o;
            prev_ack   = dmem_ack_i;
            prev_we    = dmem_we_o;
            prev_addr  = dmem_addr_o;
            prev_mask  = dmem_mask_o;
            prev_wdata = dmem_wdata_o;
        end
    end

    initial begin
        void'($urandom(25844));
        rst           = 1'b1;
        instr_valid_i = 1'b0;
        mem_read_i    = 1'b0;
        mem_write_i   = 1'b0;
        funct3_i      = F3_W;
        wb_sel_i      = WB_ALU;
        reg_write_i   = 1'b0;
        rd_i          = '0;
        alu_out_i     = '0;
        store_data_i  = '0;
        pc_plus4_i    = '0;
        u_imm_i       = '0;
        halt_i        = 1'b0;
        rs_addr_i     = '0;
        halt_seen     = 1'b0;
        exp_we = 1'b0;
        exp_addr = '0;
        exp_mask = '0;
        exp_wdata = '0;
        for (int i = 0; i < 256; i++) ref_mem[i] = fill_word(i);
        for (int i = 0; i < 32; i++) arch_regs[i] = '0;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!dmem_req_o && !stall_o && !wb_valid_o && !wb_we_o && !halt_o) else begin
            errors++;
            $display("outputs not low after reset");
        end

        @(posedge clk);
        run_ok = 1'b1;
        for (int i = 0; i < NUM_INSTR && run_ok; i++) begin
            send_random_instr(i == NUM_INSTR - 1, run_ok); // last one halts
        end
        if (run_ok) begin
            instr_valid_i <= 1'b0;
            halt_i        <= 1'b0;
            wait_for_halt(run_ok);
        end
        if (run_ok) repeat (10) @(negedge clk); // nothing may follow the halt
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected writebacks never appeared", exp_q.size());
        end

        $display("run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : mem_wb_unit_tb

`default_nettype wire

// File: bench/dmem_model.sv
`default_nettype none

module dmem_model (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        req_i,
    input  wire logic        we_i,
    input  wire logic [31:0] addr_i,
    input  wire logic [3:0]  mask_i,
    input  wire logic [31:0] wdata_i,
    output logic             ack_o,
    output logic [31:0]      rdata_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [256];
    logic [2:0]  delay;     // cycles before ack rises
    logic [2:0]  wait_cnt;
    logic [7:0]  idx;

    assign idx = addr_i[9:2];

    // every byte of the initial word depends on the full word index
    initial begin
        ack_o   = 1'b0;
        rdata_o = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i), 8'(~i), 8'(i ^ 8'h5a), 8'(i + 8'h33)};
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            ack_o    <= 1'b0;
            rdata_o  <= '0;
            wait_cnt <= '0;
            delay    <= 3'($urandom_range(4, 0));
        end else if (req_i && !ack_o) begin
            if (wait_cnt == delay) begin
                ack_o    <= 1'b1;
                rdata_o  <= mem[idx]; // old contents for a read
                wait_cnt <= '0;
                delay    <= 3'($urandom_range(4, 0));
                if (we_i) begin
                    for (int k = 0; k < 4; k++) begin
                        if (mask_i[k]) mem[idx][8*k +: 8] <= wdata_i[8*k +: 8];
                    end
                end
            end else begin
                wait_cnt <= wait_cnt + 3'd1;
            end
        end else if (!req_i && ack_o) begin
            ack_o <= 1'b0; // last phase of the handshake
        end
    end

endmodule : dmem_model

`default_nettype wire

// File: verilog/mem_wb_unit.sv
`default_nettype none

module mem_wb_unit (
    input  wire logic             clk,
    input  wire logic             rst,

    // from execute
    input  wire logic             instr_valid_i,
    input  wire logic             mem_read_i,
    input  wire logic             mem_write_i,
    input  rv32i_pkg::funct3_t    funct3_i,
    input  rv32i_pkg::wb_sel_t    wb_sel_i,
    input  wire logic             reg_write_i,
    input  rv32i_pkg::reg_idx_t   rd_i,
    input  rv32i_pkg::word_t      alu_out_i,
    input  rv32i_pkg::word_t      store_data_i,
    input  rv32i_pkg::word_t      pc_plus4_i,
    input  rv32i_pkg::word_t      u_imm_i,
    input  wire logic             halt_i,

    // data memory
    output logic                  dmem_req_o,
    output logic                  dmem_we_o,
    output rv32i_pkg::word_t      dmem_addr_o,
    output rv32i_pkg::byte_mask_t dmem_mask_o,
    output rv32i_pkg::word_t      dmem_wdata_o,
    input  wire logic             dmem_ack_i,
    input  rv32i_pkg::word_t      dmem_rdata_i,

    input  rv32i_pkg::reg_idx_t   rs_addr_i,
    output rv32i_pkg::word_t      rs_data_o,

    output logic                  stall_o,
    output logic                  wb_valid_o,
    output logic                  wb_we_o,
    output rv32i_pkg::reg_idx_t   wb_rd_o,
    output rv32i_pkg::word_t      wb_data_o,
    output logic                  halt_o
);
    import rv32i_pkg::*;

    logic     stage_done;
    word_t    mem_rdata;

    // MEM/WB fields
    logic     wb_reg_write;
    wb_sel_t  wb_sel;
    funct3_t  wb_funct3;
    logic [1:0] wb_addr_lo;
    reg_idx_t wb_rd;
    word_t    wb_alu_out;
    word_t    wb_rdata;
    word_t    wb_pc_plus4;
    word_t    wb_u_imm;

    dmem_port dmem_port0 (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .mem_read_i    (mem_read_i),
        .mem_write_i   (mem_write_i),
        .funct3_i      (funct3_i),
        .addr_i        (alu_out_i),     // effective address from execute
        .store_data_i  (store_data_i),
        .dmem_ack_i    (dmem_ack_i),
        .dmem_rdata_i  (dmem_rdata_i),
        .dmem_req_o    (dmem_req_o),
        .dmem_we_o     (dmem_we_o),
        .dmem_addr_o   (dmem_addr_o),
        .dmem_mask_o   (dmem_mask_o),
        .dmem_wdata_o  (dmem_wdata_o),
        .stall_o       (stall_o),
        .stage_done_o  (stage_done),
        .rdata_o       (mem_rdata)
    );

    mem_wb_reg mem_wb_reg0 (
        .clk         (clk),
        .rst         (rst),
        .load_i      (stage_done),
        .valid_i     (instr_valid_i),
        .reg_write_i (reg_write_i),
        .wb_sel_i    (wb_sel_i),
        .funct3_i    (funct3_i),
        .addr_lo_i   (alu_out_i[1:0]),
        .rd_i        (rd_i),
        .alu_out_i   (alu_out_i),
        .rdata_i     (mem_rdata),
        .pc_plus4_i  (pc_plus4_i),
        .u_imm_i     (u_imm_i),
        .halt_i      (halt_i),
        .valid_o     (wb_valid_o),
        .reg_write_o (wb_reg_write),
        .wb_sel_o    (wb_sel),
        .funct3_o    (wb_funct3),
        .addr_lo_o   (wb_addr_lo),
        .rd_o        (wb_rd),
        .alu_out_o   (wb_alu_out),
        .rdata_o     (wb_rdata),
        .pc_plus4_o  (wb_pc_plus4),
        .u_imm_o     (wb_u_imm),
        .halt_o      (halt_o)
    );

    wb_select wb_select0 (
        .valid_i     (wb_valid_o),
        .reg_write_i (wb_reg_write),
        .wb_sel_i    (wb_sel),
        .funct3_i    (wb_funct3),
        .addr_lo_i   (wb_addr_lo),
        .rd_i        (wb_rd),
        .alu_out_i   (wb_alu_out),
        .rdata_i     (wb_rdata),
        .pc_plus4_i  (wb_pc_plus4),
        .u_imm_i     (wb_u_imm),
        .we_o        (wb_we_o),
        .rd_o        (wb_rd_o),
        .data_o      (wb_data_o)
    );

    reg_file reg_file0 (
        .clk     (clk),
        .rst     (rst),
        .we_i    (wb_we_o),
        .waddr_i (wb_rd_o),
        .wdata_i (wb_data_o),
        .raddr_i (rs_addr_i),
        .rdata_o (rs_data_o)
    );

endmodule : mem_wb_unit

`default_nettype wire

// File: verilog/reg_file.sv
`default_nettype none

module reg_file (
    input  wire logic            clk,
    input  wire logic            rst,

    input  wire logic            we_i,
    input  rv32i_pkg::reg_idx_t  waddr_i,
    input  rv32i_pkg::word_t     wdata_i,

    input  rv32i_pkg::reg_idx_t  raddr_i,
    output rv32i_pkg::word_t     rdata_o
);
    import rv32i_pkg::*;

    word_t regs [31:1]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // no write bypass, new value shows the cycle after the write
    assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule : reg_file

`default_nettype wire

// File: verilog/wb_select.sv
`default_nettype none

module wb_select (
    input  wire logic            valid_i,
    input  wire logic            reg_write_i,
    input  rv32i_pkg::wb_sel_t   wb_sel_i,
    input  rv32i_pkg::funct3_t   funct3_i,
    input  wire logic [1:0]      addr_lo_i,
    input  rv32i_pkg::reg_idx_t  rd_i,
    input  rv32i_pkg::word_t     alu_out_i,
    input  rv32i_pkg::word_t     rdata_i,
    input  rv32i_pkg::word_t     pc_plus4_i,
    input  rv32i_pkg::word_t     u_imm_i,

    output logic                 we_o,
    output rv32i_pkg::reg_idx_t  rd_o,
    output rv32i_pkg::word_t     data_o
);
    import rv32i_pkg::*;

    word_t lane;      // addressed byte or half moved down to bit 0
    word_t load_val;

    assign lane = rdata_i >> {addr_lo_i, 3'b000};

    always_comb begin
        case (funct3_i)
            F3_B:    load_val = {{24{lane[7]}}, lane[7:0]};
            F3_H:    load_val = {{16{lane[15]}}, lane[15:0]};
            F3_BU:   load_val = {24'h0, lane[7:0]};
            F3_HU:   load_val = {16'h0, lane[15:0]};
            default: load_val = rdata_i; // full word, already aligned
        endcase
    end

    always_comb begin
        case (wb_sel_i)
            WB_MEM:  data_o = load_val;
            WB_PC4:  data_o = pc_plus4_i; // jal / jalr link
            WB_IMM:  data_o = u_imm_i;    // lui
            default: data_o = alu_out_i;
        endcase
    end

    // x0 is never written
    assign we_o = valid_i & reg_write_i & (rd_i != '0);
    assign rd_o = rd_i;

endmodule : wb_select

`default_nettype wire

// File: verilog/mem_wb_reg.sv
`default_nettype none

module mem_wb_reg (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            load_i,

    input  wire logic            valid_i,
    input  wire logic            reg_write_i,
    input  rv32i_pkg::wb_sel_t   wb_sel_i,
    input  rv32i_pkg::funct3_t   funct3_i,
    input  wire logic [1:0]      addr_lo_i,
    input  rv32i_pkg::reg_idx_t  rd_i,
    input  rv32i_pkg::word_t     alu_out_i,
    input  rv32i_pkg::word_t     rdata_i,
    input  rv32i_pkg::word_t     pc_plus4_i,
    input  rv32i_pkg::word_t     u_imm_i,
    input  wire logic            halt_i,

    output logic                 valid_o,
    output logic                 reg_write_o,
    output rv32i_pkg::wb_sel_t   wb_sel_o,
    output rv32i_pkg::funct3_t   funct3_o,
    output logic [1:0]           addr_lo_o,
    output rv32i_pkg::reg_idx_t  rd_o,
    output rv32i_pkg::word_t     alu_out_o,
    output rv32i_pkg::word_t     rdata_o,
    output rv32i_pkg::word_t     pc_plus4_o,
    output rv32i_pkg::word_t     u_imm_o,
    output logic                 halt_o
);
    import rv32i_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o     <= 1'b0;
            reg_write_o <= 1'b0;
            wb_sel_o    <= WB_ALU;
            funct3_o    <= '0;
            addr_lo_o   <= '0;
            rd_o        <= '0;
            alu_out_o   <= '0;
            rdata_o     <= '0;
            pc_plus4_o  <= '0;
            u_imm_o     <= '0;
            halt_o      <= 1'b0;
        end else if (load_i) begin
            valid_o     <= valid_i;
            reg_write_o <= reg_write_i;
            wb_sel_o    <= wb_sel_i;
            funct3_o    <= funct3_i;
            addr_lo_o   <= addr_lo_i;
            rd_o        <= rd_i;
            alu_out_o   <= alu_out_i;
            rdata_o     <= rdata_i;
            pc_plus4_o  <= pc_plus4_i;
            u_imm_o     <= u_imm_i;
            halt_o      <= halt_i;
        end else begin
            // memory stage still busy, insert a bubble
            valid_o <= 1'b0;
            halt_o  <= 1'b0; // halt only leaves together with its instruction
        end
    end

endmodule : mem_wb_reg

`default_nettype wire

// File: verilog/dmem_port.sv
`default_nettype none

module dmem_port (
    input  wire logic                clk,
    input  wire logic                rst,

    input  wire logic                instr_valid_i,
    input  wire logic                mem_read_i,
    input  wire logic                mem_write_i,
    input  rv32i_pkg::funct3_t       funct3_i,
    input  rv32i_pkg::word_t         addr_i,
    input  rv32i_pkg::word_t         store_data_i,

    input  wire logic                dmem_ack_i,
    input  rv32i_pkg::word_t         dmem_rdata_i,

    output logic                     dmem_req_o,
    output logic                     dmem_we_o,
    output rv32i_pkg::word_t         dmem_addr_o,
    output rv32i_pkg::byte_mask_t    dmem_mask_o,
    output rv32i_pkg::word_t         dmem_wdata_o,

    output logic                     stall_o,
    output logic                     stage_done_o,
    output rv32i_pkg::word_t         rdata_o
);
    import rv32i_pkg::*;

    dmem_state_t state_q, state_d;
    word_t       rdata_q;    // raw word as returned by memory
    logic        is_mem;
    logic [4:0]  shamt;      // lane offset in bits

    assign is_mem = instr_valid_i & (mem_read_i | mem_write_i);
    assign shamt  = {addr_i[1:0], 3'b000};

    always_comb begin
        state_d = state_q;
        case (state_q)
            DM_IDLE:    if (is_mem) state_d = DM_REQ;
            DM_REQ:     if (dmem_ack_i) state_d = DM_RELEASE;
            DM_RELEASE: if (!dmem_ack_i) state_d = DM_DONE;
            default:    state_d = DM_IDLE; // DM_DONE lasts one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= DM_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // read data is only valid while ack is high
    always_ff @(posedge clk) begin
        if (state_q == DM_REQ && dmem_ack_i) begin
            rdata_q <= dmem_rdata_i;
        end
    end

    // lane mask and lane-shifted store data
    always_comb begin
        case (funct3_i)
            F3_B, F3_BU: begin
                dmem_mask_o  = byte_mask_t'(4'b0001 << addr_i[1:0]);
                dmem_wdata_o = {24'h0, store_data_i[7:0]} << shamt;
            end
            F3_H, F3_HU: begin
                dmem_mask_o  = byte_mask_t'(4'b0011 << {addr_i[1], 1'b0});
                dmem_wdata_o = {16'h0, store_data_i[15:0]} << {addr_i[1], 4'b0000};
            end
            default: begin
                dmem_mask_o  = 4'b1111;
                dmem_wdata_o = store_data_i;
            end
        endcase
    end

    assign dmem_req_o  = (state_q == DM_REQ);
    assign dmem_we_o   = mem_write_i;
    assign dmem_addr_o = {addr_i[XLEN-1:2], 2'b00}; // word aligned

    // stall from first sight of a memory op until DONE
    assign stall_o = (state_q == DM_IDLE) ? is_mem : (state_q != DM_DONE);

    // non-memory ops finish in the cycle they are presented
    assign stage_done_o = (state_q == DM_DONE) |
                          ((state_q == DM_IDLE) & instr_valid_i & ~is_mem);

    assign rdata_o = rdata_q;

endmodule : dmem_port

`default_nettype wire

// File: common/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    // widths fixed by the ISA
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;     // data and addresses
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;  // register index
    typedef logic [XLEN/8-1:0]     byte_mask_t; // one bit per byte lane

    // load/store size, funct3 field of the instruction
    typedef logic [2:0] funct3_t;

    localparam funct3_t F3_B  = 3'd0; // byte, sign extended
    localparam funct3_t F3_H  = 3'd1; // halfword, sign extended
    localparam funct3_t F3_W  = 3'd2; // word
    localparam funct3_t F3_BU = 3'd4; // byte, zero extended
    localparam funct3_t F3_HU = 3'd5; // halfword, zero extended

    // source of the register write value
    typedef enum logic [1:0] {
        WB_ALU = 2'b00,
        WB_MEM = 2'b01,
        WB_PC4 = 2'b10,
        WB_IMM = 2'b11
    } wb_sel_t;

    // four-phase req/ack master towards data memory
    typedef enum logic [1:0] {
        DM_IDLE    = 2'b00, // no transfer, waiting for a memory instruction
        DM_REQ     = 2'b01, // req high, waiting for ack
        DM_RELEASE = 2'b10, // req dropped, waiting for ack to fall
        DM_DONE    = 2'b11  // handshake over, stage completes this cycle
    } dmem_state_t;

endpackage : rv32i_pkg

`default_nettype wire
